// ==== exec_unit.sv ====
`timescale 1ns/1ps
`include "rv_exec_settings.svh"

module exec_unit (
    input  logic                   clk,
    input  logic                   arst_n,
    input  rv_exec_pkg::exec_req_t req,
    input  rv_exec_pkg::ctl_t      ctl,
    input  rv_exec_pkg::word_t     imm,
    output rv_exec_pkg::exec_rsp_t rsp
);

    rv_exec_pkg::word_t op_a;
    rv_exec_pkg::word_t op_b;
    rv_exec_pkg::word_t alu_out;
    rv_exec_pkg::word_t pc4;
    rv_exec_pkg::word_t wb_data;
    rv_exec_pkg::word_t next_pc;
    logic [4:0]         shamt;
    logic               br_taken;

    logic               valid_q;
    logic               reg_wen_q;
    logic               mem_wr_q;
    logic               mem_rd_q;
    logic               illegal_q;
    rv_exec_pkg::word_t next_pc_q;
    rv_exec_pkg::word_t alu_out_q;
    rv_exec_pkg::word_t wb_data_q;
    logic [4:0]         rd_q;

    assign op_a  = ctl.a_sel ? req.pc : req.rs1_val;
    assign op_b  = ctl.b_sel ? imm : req.rs2_val;
    assign shamt = op_b[4:0];
    assign pc4   = req.pc + `RV_XLEN'd4;

    always_comb begin
        case (ctl.alu_op)
            rv_exec_pkg::ALU_ADD:    alu_out = op_a + op_b;
            rv_exec_pkg::ALU_SUB:    alu_out = op_a - op_b;
            rv_exec_pkg::ALU_AND:    alu_out = op_a & op_b;
            rv_exec_pkg::ALU_OR:     alu_out = op_a | op_b;
            rv_exec_pkg::ALU_XOR:    alu_out = op_a ^ op_b;
            rv_exec_pkg::ALU_SLL:    alu_out = op_a << shamt;
            rv_exec_pkg::ALU_SRL:    alu_out = op_a >> shamt;
            rv_exec_pkg::ALU_SRA:    alu_out = $signed(op_a) >>> shamt;
            rv_exec_pkg::ALU_SLT:    alu_out = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            rv_exec_pkg::ALU_SLTU:   alu_out = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            rv_exec_pkg::ALU_PASS_B: alu_out = op_b;
            default:                 alu_out = '0;
        endcase
    end

    // Branch compare always works on the register values
    always_comb begin
        case (ctl.br_op)
            rv_exec_pkg::BR_EQ:  br_taken = (req.rs1_val == req.rs2_val);
            rv_exec_pkg::BR_NE:  br_taken = (req.rs1_val != req.rs2_val);
            rv_exec_pkg::BR_LT:  br_taken = $signed(req.rs1_val) < $signed(req.rs2_val);
            rv_exec_pkg::BR_GE:  br_taken = $signed(req.rs1_val) >= $signed(req.rs2_val);
            rv_exec_pkg::BR_LTU: br_taken = req.rs1_val < req.rs2_val;
            rv_exec_pkg::BR_GEU: br_taken = req.rs1_val >= req.rs2_val;
            default:             br_taken = 1'b0;
        endcase
    end

    assign wb_data = (ctl.wb_sel == rv_exec_pkg::WB_PC4) ? pc4 : alu_out;

    // JALR drops bit 0, a JAL target is even anyway
    always_comb begin
        if (ctl.jump) begin
            next_pc = {alu_out[`RV_XLEN-1:1], 1'b0};
        end else if (br_taken) begin
            next_pc = alu_out;
        end else begin
            next_pc = pc4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q   <= 1'b0;
            reg_wen_q <= 1'b0;
            mem_wr_q  <= 1'b0;
            mem_rd_q  <= 1'b0;
            illegal_q <= 1'b0;
            next_pc_q <= `RV_RESET_PC;
        end else begin
            valid_q <= req.valid;
            if (req.valid) begin
                reg_wen_q <= ctl.reg_wen;
                mem_wr_q  <= ctl.mem_wr;
                mem_rd_q  <= ctl.mem_rd;
                illegal_q <= ctl.illegal;
                next_pc_q <= next_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req.valid) begin
            alu_out_q <= alu_out;
            wb_data_q <= wb_data;
            rd_q      <= req.instr.r.rd;
        end
    end

    assign rsp.valid   = valid_q;
    assign rsp.alu_out = alu_out_q;
    assign rsp.wb_data = wb_data_q;
    assign rsp.next_pc = next_pc_q;
    assign rsp.rd      = rd_q;
    assign rsp.reg_wen = reg_wen_q;
    assign rsp.mem_wr  = mem_wr_q;
    assign rsp.mem_rd  = mem_rd_q;
    assign rsp.illegal = illegal_q;

endmodule

// ==== imm_gen.sv ====
`timescale 1ns/1ps
`include "rv_exec_settings.svh"

module imm_gen (
    input  rv_exec_pkg::instr_u   instr,
    input  rv_exec_pkg::imm_sel_e imm_sel,
    output rv_exec_pkg::word_t    imm
);

    always_comb begin
        case (imm_sel)
            rv_exec_pkg::IMM_I: begin
                imm = {{(`RV_XLEN-12){instr.i.imm12[11]}}, instr.i.imm12};
            end
            rv_exec_pkg::IMM_S: begin
                imm = {{(`RV_XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
            end
            // imm[12|10:5] in imm_hi, imm[4:1|11] in imm_lo
            rv_exec_pkg::IMM_B: begin
                imm = {{(`RV_XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_lo[0],
                       instr.s.imm_hi[5:0], instr.s.imm_lo[4:1], 1'b0};
            end
            rv_exec_pkg::IMM_U: begin
                imm = {{(`RV_XLEN-31){instr.i.imm12[11]}}, instr.i.imm12[10:0],
                       instr.i.rs1, instr.i.funct3, 12'h000};
            end
            // imm[20|10:1|11] in imm12, imm[19:12] in rs1 and funct3
            rv_exec_pkg::IMM_J: begin
                imm = {{(`RV_XLEN-20){instr.i.imm12[11]}}, instr.i.rs1, instr.i.funct3,
                       instr.i.imm12[0], instr.i.imm12[10:1], 1'b0};
            end
            default: imm = '0;
        endcase
    end

endmodule

// ==== instr_ctl.sv ====
`timescale 1ns/1ps

module instr_ctl (
    input  rv_exec_pkg::instr_u instr,
    output rv_exec_pkg::ctl_t   ctl
);

    // OP and OP-IMM share the funct3 map, SUB only exists in OP
    function automatic rv_exec_pkg::alu_op_e alu_from_funct3(
        input logic [2:0] funct3,
        input logic       alt,
        input logic       is_reg
    );
        case (funct3)
            3'b000: begin
                if (alt && is_reg) begin
                    alu_from_funct3 = rv_exec_pkg::ALU_SUB;
                end else begin
                    alu_from_funct3 = rv_exec_pkg::ALU_ADD;
                end
            end
            3'b001: alu_from_funct3 = rv_exec_pkg::ALU_SLL;
            3'b010: alu_from_funct3 = rv_exec_pkg::ALU_SLT;
            3'b011: alu_from_funct3 = rv_exec_pkg::ALU_SLTU;
            3'b100: alu_from_funct3 = rv_exec_pkg::ALU_XOR;
            3'b101: alu_from_funct3 = alt ? rv_exec_pkg::ALU_SRA : rv_exec_pkg::ALU_SRL;
            3'b110: alu_from_funct3 = rv_exec_pkg::ALU_OR;
            default: alu_from_funct3 = rv_exec_pkg::ALU_AND;
        endcase
    endfunction

    always_comb begin
        ctl.a_sel   = 1'b0;
        ctl.b_sel   = 1'b1;
        ctl.alu_op  = rv_exec_pkg::ALU_ADD;
        ctl.imm_sel = rv_exec_pkg::IMM_I;
        ctl.br_op   = rv_exec_pkg::BR_NONE;
        ctl.jump    = 1'b0;
        ctl.reg_wen = 1'b0;
        ctl.mem_wr  = 1'b0;
        ctl.mem_rd  = 1'b0;
        ctl.wb_sel  = rv_exec_pkg::WB_ALU;
        ctl.illegal = 1'b0;

        case (instr.r.opcode)
            rv_exec_pkg::OPC_LUI: begin
                ctl.alu_op  = rv_exec_pkg::ALU_PASS_B;
                ctl.imm_sel = rv_exec_pkg::IMM_U;
                ctl.reg_wen = 1'b1;
            end
            rv_exec_pkg::OPC_AUIPC: begin
                ctl.a_sel   = 1'b1;
                ctl.imm_sel = rv_exec_pkg::IMM_U;
                ctl.reg_wen = 1'b1;
            end
            rv_exec_pkg::OPC_JAL: begin
                ctl.a_sel   = 1'b1;
                ctl.imm_sel = rv_exec_pkg::IMM_J;
                ctl.jump    = 1'b1;
                ctl.reg_wen = 1'b1;
                ctl.wb_sel  = rv_exec_pkg::WB_PC4;
            end
            rv_exec_pkg::OPC_JALR: begin
                ctl.jump    = 1'b1;
                ctl.reg_wen = 1'b1;
                ctl.wb_sel  = rv_exec_pkg::WB_PC4;
                ctl.illegal = (instr.r.funct3 != 3'b000);
            end
            rv_exec_pkg::OPC_BRANCH: begin
                // ALU forms the target pc+imm
                ctl.a_sel   = 1'b1;
                ctl.imm_sel = rv_exec_pkg::IMM_B;
                case (instr.r.funct3)
                    3'b000: ctl.br_op = rv_exec_pkg::BR_EQ;
                    3'b001: ctl.br_op = rv_exec_pkg::BR_NE;
                    3'b100: ctl.br_op = rv_exec_pkg::BR_LT;
                    3'b101: ctl.br_op = rv_exec_pkg::BR_GE;
                    3'b110: ctl.br_op = rv_exec_pkg::BR_LTU;
                    3'b111: ctl.br_op = rv_exec_pkg::BR_GEU;
                    default: ctl.illegal = 1'b1;
                endcase
            end
            rv_exec_pkg::OPC_LOAD: begin
                ctl.reg_wen = 1'b1;
                ctl.mem_rd  = 1'b1;
                ctl.wb_sel  = rv_exec_pkg::WB_MEM;
                case (instr.r.funct3)
                    3'b000, 3'b001, 3'b010, 3'b100, 3'b101: ctl.illegal = 1'b0;
                    default: ctl.illegal = 1'b1;
                endcase
            end
            rv_exec_pkg::OPC_STORE: begin
                ctl.imm_sel = rv_exec_pkg::IMM_S;
                ctl.mem_wr  = 1'b1;
                ctl.illegal = (instr.r.funct3 > 3'b010);
            end
            rv_exec_pkg::OPC_OP_IMM: begin
                ctl.alu_op  = alu_from_funct3(instr.r.funct3, instr.r.funct7[5], 1'b0);
                ctl.reg_wen = 1'b1;
            end
            rv_exec_pkg::OPC_OP: begin
                ctl.b_sel   = 1'b0;
                ctl.alu_op  = alu_from_funct3(instr.r.funct3, instr.r.funct7[5], 1'b1);
                ctl.reg_wen = 1'b1;
            end
            default: ctl.illegal = 1'b1;
        endcase

        // Nothing may change state for an illegal word
        if (ctl.illegal) begin
            ctl.br_op   = rv_exec_pkg::BR_NONE;
            ctl.jump    = 1'b0;
            ctl.reg_wen = 1'b0;
            ctl.mem_wr  = 1'b0;
            ctl.mem_rd  = 1'b0;
        end
    end

endmodule

// ==== rv_exec_asserts.sv ====
`timescale 1ns/1ps

module rv_exec_asserts (
    input logic                   clk,
    input logic                   arst_n,
    input rv_exec_pkg::exec_req_t req,
    input rv_exec_pkg::exec_rsp_t rsp
);

    int unsigned fail_count = 0;

    // One cycle latency, one result per request
    valid_follows_req: assert property (@(posedge clk) disable iff (!arst_n)
        rsp.valid == $past(req.valid))
        else begin
            fail_count++;
            $error("rsp.valid is not the previous req.valid");
        end

    store_not_write: assert property (@(posedge clk) disable iff (!arst_n)
        !(rsp.mem_wr && rsp.reg_wen))
        else begin
            fail_count++;
            $error("mem_wr and reg_wen set together");
        end

    illegal_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        rsp.illegal |-> !(rsp.reg_wen || rsp.mem_wr || rsp.mem_rd))
        else begin
            fail_count++;
            $error("illegal instruction with an enable set");
        end

    pc_even: assert property (@(posedge clk) disable iff (!arst_n)
        !rsp.next_pc[0])
        else begin
            fail_count++;
            $error("next_pc bit 0 set");
        end

endmodule

bind exec_unit rv_exec_asserts u_exec_asserts (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .rsp    (rsp)
);

// ==== rv_exec_pkg.sv ====
`include "rv_exec_settings.svh"

package rv_exec_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLL    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_SLT    = 4'd8,
        ALU_SLTU   = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } imm_sel_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } br_op_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_PC4 = 2'd1,
        WB_MEM = 2'd2
    } wb_sel_e;

    // Per-format views of the same instruction word
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } instr_s_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
        instr_s_t s;
    } instr_u;

    typedef struct packed {
        logic     a_sel;
        logic     b_sel;
        alu_op_e  alu_op;
        imm_sel_e imm_sel;
        br_op_e   br_op;
        logic     jump;
        logic     reg_wen;
        logic     mem_wr;
        logic     mem_rd;
        wb_sel_e  wb_sel;
        logic     illegal;
    } ctl_t;

    typedef struct packed {
        logic   valid;
        instr_u instr;
        word_t  pc;
        word_t  rs1_val;
        word_t  rs2_val;
    } exec_req_t;

    typedef struct packed {
        logic       valid;
        word_t      alu_out;
        word_t      wb_data;
        word_t      next_pc;
        logic [4:0] rd;
        logic       reg_wen;
        logic       mem_wr;
        logic       mem_rd;
        logic       illegal;
    } exec_rsp_t;

endpackage

// ==== rv_exec_settings.svh ====
`ifndef RV_EXEC_SETTINGS_SVH
`define RV_EXEC_SETTINGS_SVH

// Data path width
`define RV_XLEN 32

// Value of next_pc held in the result register after reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== rv_exec_tb.sv ====
`timescale 1ns/1ps
`include "rv_exec_settings.svh"

module rv_exec_tb;

    localparam int unsigned NT     = 41;
    localparam int unsigned REPS   = 4;
    localparam int unsigned N_RAND = 600;
    localparam int unsigned LIMIT  = 10 + NT * REPS + N_RAND + 20;

    // Fixed opcode and funct bits per template, the rest is random
    localparam logic [31:0] TPL [NT] = '{
        32'h0000_0033, 32'h4000_0033, 32'h0000_1033, 32'h0000_2033, 32'h0000_3033,
        32'h0000_4033, 32'h0000_5033, 32'h4000_5033, 32'h0000_6033, 32'h0000_7033,
        32'h0000_0013, 32'h0000_1013, 32'h0000_2013, 32'h0000_3013, 32'h0000_4013,
        32'h0000_5013, 32'h4000_5013, 32'h0000_6013, 32'h0000_7013, 32'h0000_0037,
        32'h0000_0017, 32'h0000_006f, 32'h0000_0067, 32'h0000_0063, 32'h0000_1063,
        32'h0000_4063, 32'h0000_5063, 32'h0000_6063, 32'h0000_7063, 32'h0000_0003,
        32'h0000_2003, 32'h0000_5003, 32'h0000_0023, 32'h0000_2023, 32'h0000_000f,
        32'h0000_0073, 32'h0000_1067, 32'h0000_2063, 32'h0000_3003, 32'h0000_3023,
        32'h0000_002b
    };

    localparam logic [31:0] EDGE [8] = '{
        32'h0000_0000, 32'h0000_0001, 32'h7fff_ffff, 32'h8000_0000,
        32'hffff_ffff, 32'h8000_0001, 32'hffff_fffe, 32'h0000_0004
    };

    logic                   clk = 1'b0;
    logic                   arst_n;
    rv_exec_pkg::exec_req_t req;
    rv_exec_pkg::exec_rsp_t rsp;
    rv_exec_pkg::exec_rsp_t exp_q;
    logic                   seen_q;
    logic [31:0]            lfsr;
    int unsigned            cycles = 0;

    rv_exec_top UUT (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .rsp    (rsp)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        take_bits = v;
    endfunction

    function automatic logic [31:0] rand_mask(input logic [31:0] w);
        if (w[6:0] == 7'h33 || (w[6:0] == 7'h13 && w[13:12] == 2'b01)) begin
            rand_mask = 32'h01ff_8f80;
        end else if (w[6:0] == 7'h37 || w[6:0] == 7'h17 || w[6:0] == 7'h6f) begin
            rand_mask = 32'hffff_ff80;
        end else begin
            rand_mask = 32'hffff_8f80;
        end
    endfunction

    // Edge values or a copy of the other operand, so compares hit the boundaries
    function automatic rv_exec_pkg::word_t draw_value(input rv_exec_pkg::word_t other);
        logic [31:0] sel;
        sel = take_bits(2);
        case (sel[1:0])
            2'd0: draw_value = EDGE[take_bits(3)];
            2'd1: draw_value = other;
            default: draw_value = take_bits(32);
        endcase
    endfunction

    function automatic rv_exec_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                                   input rv_exec_pkg::word_t x,
                                                   input rv_exec_pkg::word_t y);
        case (f3)
            3'd0: alu_ref = alt ? x - y : x + y;
            3'd1: alu_ref = x << y[4:0];
            3'd2: alu_ref = ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3: alu_ref = (x < y) ? 32'd1 : 32'd0;
            3'd4: alu_ref = x ^ y;
            3'd5: begin
                if (alt) begin
                    alu_ref = $signed(x) >>> y[4:0];
                end else begin
                    alu_ref = x >> y[4:0];
                end
            end
            3'd6: alu_ref = x | y;
            default: alu_ref = x & y;
        endcase
    endfunction

    function automatic rv_exec_pkg::exec_rsp_t rv_ref(input rv_exec_pkg::exec_req_t r);
        rv_exec_pkg::exec_rsp_t e;
        logic [31:0]            w;
        logic [2:0]             f3;
        rv_exec_pkg::word_t     a;
        rv_exec_pkg::word_t     b;
        rv_exec_pkg::word_t     pc4;
        rv_exec_pkg::word_t     im_i;
        rv_exec_pkg::word_t     im_b;
        logic                   taken;
        logic                   is_jump;
        w       = r.instr;
        f3      = w[14:12];
        a       = r.rs1_val;
        b       = r.rs2_val;
        pc4     = r.pc + 32'd4;
        im_i    = {{20{w[31]}}, w[31:20]};
        im_b    = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        taken   = 1'b0;
        is_jump = 1'b0;
        e       = '0;
        e.valid = 1'b1;
        e.rd    = w[11:7];
        case (w[6:0])
            7'h37: begin
                e.alu_out = {w[31:12], 12'h000};
                e.reg_wen = 1'b1;
            end
            7'h17: begin
                e.alu_out = r.pc + {w[31:12], 12'h000};
                e.reg_wen = 1'b1;
            end
            7'h6f: begin
                e.alu_out = r.pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
                e.reg_wen = 1'b1;
                is_jump   = 1'b1;
            end
            7'h67: begin
                e.alu_out = a + im_i;
                e.reg_wen = 1'b1;
                is_jump   = 1'b1;
                e.illegal = (f3 != 3'd0);
            end
            7'h63: begin
                e.alu_out = r.pc + im_b;
                case (f3)
                    3'd0: taken = (a == b);
                    3'd1: taken = (a != b);
                    3'd4: taken = ($signed(a) < $signed(b));
                    3'd5: taken = ($signed(a) >= $signed(b));
                    3'd6: taken = (a < b);
                    3'd7: taken = (a >= b);
                    default: e.illegal = 1'b1;
                endcase
            end
            7'h03: begin
                e.alu_out = a + im_i;
                e.reg_wen = 1'b1;
                e.mem_rd  = 1'b1;
                e.illegal = (f3 == 3'd3) || (f3 > 3'd5);
            end
            7'h23: begin
                e.alu_out = a + {{20{w[31]}}, w[31:25], w[11:7]};
                e.mem_wr  = 1'b1;
                e.illegal = (f3 > 3'd2);
            end
            7'h13: begin
                e.alu_out = alu_ref(f3, (f3 == 3'd5) && w[30], a, im_i);
                e.reg_wen = 1'b1;
            end
            7'h33: begin
                e.alu_out = alu_ref(f3, w[30], a, b);
                e.reg_wen = 1'b1;
            end
            default: e.illegal = 1'b1;
        endcase
        e.wb_data = is_jump ? pc4 : e.alu_out;
        e.next_pc = pc4;
        if (e.illegal) begin
            e.reg_wen = 1'b0;
            e.mem_wr  = 1'b0;
            e.mem_rd  = 1'b0;
        end else if (is_jump) begin
            e.next_pc = {e.alu_out[31:1], 1'b0};
        end else if (taken) begin
            e.next_pc = r.pc + im_b;
        end
        rv_ref = e;
    endfunction

    task automatic check_word(input string name, input rv_exec_pkg::word_t exp,
                              input rv_exec_pkg::word_t act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %h actual %h", $time, name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %b actual %b", $time, name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_rd(input string name, input logic [4:0] exp, input logic [4:0] act);
        if (act !== exp) begin
            $display("[FAIL] %0t ns %s expected %0d actual %0d", $time, name, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "rd mismatch");
        end
    endtask

    task automatic send_request(input int unsigned t);
        logic [31:0] pc_bits;
        req.instr   = (take_bits(32) & rand_mask(TPL[t])) | TPL[t];
        pc_bits     = take_bits(30);
        req.pc      = pc_bits << 2;
        req.rs1_val = draw_value(32'h0);
        req.rs2_val = draw_value(req.rs1_val);
        req.valid   = 1'b1;
    endtask

    // Result of the previous edge's request, fields held while valid is low
    always @(posedge clk) begin
        if (arst_n) begin
            check_flag("rsp.valid", exp_q.valid, rsp.valid);
            check_flag("rsp.reg_wen", exp_q.reg_wen, rsp.reg_wen);
            check_flag("rsp.mem_wr", exp_q.mem_wr, rsp.mem_wr);
            check_flag("rsp.mem_rd", exp_q.mem_rd, rsp.mem_rd);
            check_flag("rsp.illegal", exp_q.illegal, rsp.illegal);
            check_word("rsp.next_pc", exp_q.next_pc, rsp.next_pc);
            if (seen_q) begin
                check_rd("rsp.rd", exp_q.rd, rsp.rd);
                if (!exp_q.illegal) begin
                    check_word("rsp.alu_out", exp_q.alu_out, rsp.alu_out);
                    check_word("rsp.wb_data", exp_q.wb_data, rsp.wb_data);
                end
            end
            if (req.valid) begin
                exp_q  = rv_ref(req);
                seen_q = 1'b1;
            end else begin
                exp_q.valid = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: run still going after %0d cycles", LIMIT);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int unsigned t;
        int unsigned i;
        logic [31:0] pick;
        logic [31:0] gap;
        lfsr          = 32'hb3c41e07;
        arst_n        = 1'b0;
        req           = '0;
        exp_q         = '0;
        exp_q.next_pc = `RV_RESET_PC;
        seen_q        = 1'b0;
        repeat (10) @(negedge clk);
        check_flag("rsp.valid", 1'b0, rsp.valid);
        check_flag("rsp.reg_wen", 1'b0, rsp.reg_wen);
        check_flag("rsp.mem_wr", 1'b0, rsp.mem_wr);
        check_flag("rsp.mem_rd", 1'b0, rsp.mem_rd);
        check_flag("rsp.illegal", 1'b0, rsp.illegal);
        check_word("rsp.next_pc", `RV_RESET_PC, rsp.next_pc);
        arst_n = 1'b1;

        // Every template back to back
        for (t = 0; t < NT; t++) begin
            repeat (REPS) begin
                @(negedge clk);
                send_request(t);
            end
        end

        // Random mix, gaps still change the other request fields
        for (i = 0; i < N_RAND; i++) begin
            @(negedge clk);
            pick = take_bits(6);
            send_request(pick % NT);
            gap = take_bits(2);
            if (gap == 0) begin
                req.valid = 1'b0;
            end
        end
        @(negedge clk);
        req.valid = 1'b0;
        repeat (3) @(negedge clk);

        if (UUT.u_exec_unit.u_exec_asserts.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("%0d assertion failures", UUT.u_exec_unit.u_exec_asserts.fail_count);
            $display("TESTS FAILED");
            $fatal(1, "assertion failures");
        end
    end

endmodule

// ==== rv_exec_top.f ====
+incdir+.
rv_exec_pkg.sv
instr_ctl.sv
imm_gen.sv
exec_unit.sv
rv_exec_top.sv
rv_exec_asserts.sv
rv_exec_tb.sv

// ==== rv_exec_top.sv ====
`timescale 1ns/1ps

module rv_exec_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  rv_exec_pkg::exec_req_t req,
    output rv_exec_pkg::exec_rsp_t rsp
);

    rv_exec_pkg::ctl_t  ctl;
    rv_exec_pkg::word_t imm;

    instr_ctl u_instr_ctl (
        .instr (req.instr),
        .ctl   (ctl)
    );

    // Format choice comes from the decoder
    imm_gen u_imm_gen (
        .instr   (req.instr),
        .imm_sel (ctl.imm_sel),
        .imm     (imm)
    );

    exec_unit u_exec_unit (
        .clk    (clk),
        .arst_n (arst_n),
        .req    (req),
        .ctl    (ctl),
        .imm    (imm),
        .rsp    (rsp)
    );

endmodule
